//--- src/audio_pkg.sv
package audio_pkg;

    // --------------------
    // word widths
    // --------------------

    // the INMP441 delivers 24 significant bits per slot
    localparam int mic_bits = 24;

    // playback word, the upper part of the microphone word
    localparam int out_bits = 16;

    // --------------------
    // frame shape
    // --------------------

    // sck periods per microphone slot, two slots per ws frame
    localparam int mic_slot_sck  = 32;

    // bclk periods per playback slot, two slots per lrclk frame
    localparam int out_slot_bclk = 16;

    // --------------------
    // sample payload
    // --------------------

    // one playback word, passed receiver -> fifo -> serializer
    typedef struct packed
    {
        logic signed [out_bits - 1:0] pcm;  // two's complement audio
    } sample_t;

endpackage

//--- src/mic_i2s_receiver.sv
`timescale 1ns/1ps

module mic_i2s_receiver
# (
    parameter sck_div    = 4,  // clk cycles per sck half period
              fifo_depth = 8   // credits held after reset
)
(
    input                      clk,
    input                      rst_n,

    output logic               sck,
    output                     ws,
    input                      sd,

    output logic               sample_valid,
    output audio_pkg::sample_t sample,
    input                      credit,

    output logic               overrun
);

    localparam int dw = $clog2(sck_div + 1);
    localparam int fw = $clog2(2 * audio_pkg::mic_slot_sck);  // bits of the frame counter
    localparam int sw = fw - 1;                                // bits of the slot position
    localparam int cw = $clog2(fifo_depth + 1);

    logic [dw - 1:0] div_cnt;
    logic [fw - 1:0] bit_cnt;    // counts sck falling edges
    logic [cw - 1:0] credit_cnt;

    logic [audio_pkg::mic_bits - 1:0] shift_q;

    // --------------------
    // sck and ws
    // --------------------

    wire tick     = div_cnt == dw'(sck_div - 1);
    wire sck_rise = tick & ~ sck;
    wire sck_fall = tick &   sck;

    always_ff @ (posedge clk)
    begin
        if (! rst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            if (tick)
            begin
                div_cnt <= '0;
                sck     <= ~ sck;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;  // ws flips when the slot wraps
        end
    end

    assign ws = bit_cnt [fw - 1];  // low = left slot

    // --------------------
    // left word capture
    // --------------------

    wire [sw - 1:0] slot_bit = bit_cnt [sw - 1:0];
    wire            left     = ~ bit_cnt [fw - 1];

    // slot bit 0 is the i2s delay bit, data sits in bits 1 .. mic_bits
    wire shift_en = sck_rise & left & (slot_bit != '0)
                  & (slot_bit <= sw'(audio_pkg::mic_bits));

    wire word_end = sck_rise & left & (slot_bit == sw'(audio_pkg::mic_bits));

    always_ff @ (posedge clk)
        if (shift_en)
            shift_q <= { shift_q [audio_pkg::mic_bits - 2:0], sd };  // msb first

    // keep only the upper bits of the microphone word
    assign sample.pcm = shift_q [audio_pkg::mic_bits - 1 -: audio_pkg::out_bits];

    // --------------------
    // credit flow
    // --------------------

    wire have_credit = credit_cnt != '0;
    wire take        = word_end & have_credit;

    always_ff @ (posedge clk)
    begin
        if (! rst_n)
        begin
            credit_cnt   <= cw'(fifo_depth);
            sample_valid <= 1'b0;
            overrun      <= 1'b0;
        end
        else
        begin
            sample_valid <= take;  // valid while shift_q holds the full word

            if (word_end & ~ have_credit)
                overrun <= 1'b1;  // sticky, word dropped

            case ({ take, credit })
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;  // none or both cancel
            endcase
        end
    end

endmodule

//--- src/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo
# (
    parameter fifo_depth = 8
)
(
    input                      clk,
    input                      rst_n,

    input                      push,
    input  audio_pkg::sample_t din,

    input                      pop,
    output audio_pkg::sample_t head,
    output                     empty,

    output logic               credit
);

    localparam int aw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cw = $clog2(fifo_depth + 1);

    audio_pkg::sample_t mem [fifo_depth];

    logic [aw - 1:0] wr_ptr;
    logic [aw - 1:0] rd_ptr;
    logic [cw - 1:0] count;  // entries held

    // pointer step with wrap, depth need not be a power of two
    function automatic logic [aw - 1:0] next_ptr(input logic [aw - 1:0] p);
        return (p == aw'(fifo_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // --------------------
    // storage
    // --------------------

    // producer only pushes with a credit in hand, so no full check here
    always_ff @ (posedge clk)
        if (push)
            mem [wr_ptr] <= din;

    assign head  = mem [rd_ptr];  // oldest entry
    assign empty = count == '0;

    // --------------------
    // pointers and count
    // --------------------

    always_ff @ (posedge clk)
    begin
        if (! rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);

            if (pop)
                rd_ptr <= next_ptr(rd_ptr);

            case ({ push, pop })
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            credit <= pop;  // one slot freed, hand it back
        end
    end

endmodule

//--- src/i2s_audio_out.sv
`timescale 1ns/1ps

module i2s_audio_out
# (
    parameter bclk_div = 9  // clk cycles per bclk half period
)
(
    input                      clk,
    input                      rst_n,

    input                      empty,
    input  audio_pkg::sample_t head,
    output logic               pop,

    output logic               bclk,
    output                     lrclk,
    output logic               sdata
);

    localparam int dw = $clog2(bclk_div + 1);
    localparam int fw = $clog2(2 * audio_pkg::out_slot_bclk);
    localparam int sw = fw - 1;
    localparam int bw = $clog2(audio_pkg::out_bits);

    logic [dw - 1:0] div_cnt;
    logic [fw - 1:0] bit_cnt;  // bclk falling edges within the frame

    logic [audio_pkg::out_bits - 1:0] word_q;

    // --------------------
    // bclk and lrclk
    // --------------------

    wire tick      = div_cnt == dw'(bclk_div - 1);
    wire bclk_fall = tick & bclk;

    wire [fw - 1:0] bit_nxt = bit_cnt + 1'b1;

    wire frame_start = bclk_fall & (bit_cnt == '1);  // lrclk about to fall

    always_ff @ (posedge clk)
    begin
        if (! rst_n)
        begin
            div_cnt <= '0;
            bclk    <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            if (tick)
            begin
                div_cnt <= '0;
                bclk    <= ~ bclk;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (bclk_fall)
                bit_cnt <= bit_nxt;
        end
    end

    assign lrclk = bit_cnt [fw - 1];  // low = left slot

    // --------------------
    // word fetch and shift
    // --------------------

    // position 1 gets the msb, position 0 carries the lsb of the slot
    // before it, the index below wraps to 0 there
    wire [sw - 1:0] slot_pos = bit_nxt [sw - 1:0];
    wire [bw - 1:0] bit_idx  = bw'(audio_pkg::out_bits - int'(slot_pos));

    always_ff @ (posedge clk)
    begin
        if (! rst_n)
        begin
            word_q <= '0;  // first frame after reset plays silence
            pop    <= 1'b0;
            sdata  <= 1'b0;
        end
        else
        begin
            pop <= frame_start & ~ empty;

            if (frame_start)
                word_q <= empty ? '0 : head.pcm;  // underrun -> zero

            if (bclk_fall)
                sdata <= word_q [bit_idx];  // same word in both slots
        end
    end

endmodule

//--- src/audio_loopback_top.sv
`timescale 1ns/1ps

module audio_loopback_top
# (
    parameter sck_div    = 4,  // mic frame = 512 clk
              bclk_div   = 9,  // output frame = 576 clk
              fifo_depth = 8
)
(
    input  clk,
    input  rst_n,

    // INMP441 microphone
    output sck,
    output ws,
    input  sd,

    // i2s dac
    output bclk,
    output lrclk,
    output sdata,

    output overrun
);

    // --------------------
    // links between stages
    // --------------------

    wire                sample_valid;
    audio_pkg::sample_t sample;
    wire                credit;

    wire                pop;
    wire                empty;
    audio_pkg::sample_t head;

    //--------------------

    mic_i2s_receiver
    # (
        .sck_div      ( sck_div      ),
        .fifo_depth   ( fifo_depth   )
    )
    i_microphone
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sck          ( sck          ),
        .ws           ( ws           ),
        .sd           ( sd           ),
        .sample_valid ( sample_valid ),
        .sample       ( sample       ),
        .credit       ( credit       ),
        .overrun      ( overrun      )
    );

    sample_fifo
    # (
        .fifo_depth   ( fifo_depth   )
    )
    i_fifo
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .push         ( sample_valid ),
        .din          ( sample       ),
        .pop          ( pop          ),
        .head         ( head         ),
        .empty        ( empty        ),
        .credit       ( credit       )  // back to the receiver
    );

    i2s_audio_out
    # (
        .bclk_div     ( bclk_div     )
    )
    o_audio
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .empty        ( empty        ),
        .head         ( head         ),
        .pop          ( pop          ),
        .bclk         ( bclk         ),
        .lrclk        ( lrclk        ),
        .sdata        ( sdata        )
    );

endmodule

//--- dv/tb_audio_loopback.sv
`timescale 1ns/1ps

module tb_audio_loopback;

    localparam int clk_ns          = 100;
    localparam int reset_cycles    = 10;
    localparam int out_frame_clk   = 576;  // 2 slots * 16 bclk * 2 * bclk_div
    localparam int test_frames     = 100;
    localparam int watchdog_frames = 120;
    localparam int first_words     = 8;    // equals fifo_depth so none is dropped before these
    localparam int watchdog_ns     = watchdog_frames * out_frame_clk * clk_ns
                                   + reset_cycles * clk_ns;

    logic clk;
    logic rst_n;
    logic sd;

    wire  sck, ws, bclk, lrclk, sdata, overrun;

    logic [23:0] left_words  [$];  // every left word sent by the microphone
    logic [23:0] right_words [$];
    logic [15:0] dac_left    [$];  // one entry per complete output frame
    logic [15:0] dac_right   [$];

    int test_err [1:6];
    int checks;
    int overrun_falls;
    bit overrun_seen;

    audio_loopback_top u_dut
    (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .sck     ( sck     ),
        .ws      ( ws      ),
        .sd      ( sd      ),
        .bclk    ( bclk    ),
        .lrclk   ( lrclk   ),
        .sdata   ( sdata   ),
        .overrun ( overrun )
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~ clk;
    end

    // --------------------
    // helpers
    // --------------------

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return { s [30:0], s [31] ^ s [21] ^ s [1] ^ s [0] };
    endfunction

    // playback word is the upper 16 bits of the microphone word
    function automatic logic [15:0] mic_to_pcm(input logic [23:0] w);
        return w [23:8];
    endfunction

    task automatic compare_value(input int test, input string name,
                                 input logic [23:0] expected, input logic [23:0] actual);
        checks++;
        assert (actual === expected) else
        begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            test_err [test]++;
        end
    endtask

    task automatic expect_outputs_low();
        compare_value(1, "sck",     24'h0, 24'(sck));
        compare_value(1, "ws",      24'h0, 24'(ws));
        compare_value(1, "bclk",    24'h0, 24'(bclk));
        compare_value(1, "lrclk",   24'h0, 24'(lrclk));
        compare_value(1, "sdata",   24'h0, 24'(sdata));
        compare_value(1, "overrun", 24'h0, 24'(overrun));
    endtask

    task automatic report_test(input int test, input string name);
        if (test_err [test] == 0)
            $display("test %0d %s: passed", test, name);
        else
            $display("test %0d %s: failed with %0d errors", test, name, test_err [test]);
    endtask

    // --------------------
    // microphone model
    // --------------------

    initial
    begin : mic_model
        logic [31:0] lfsr_state;
        logic [23:0] word;
        logic        prev_sck;
        logic        prev_ws;
        int          pos;   // sck falls since the last ws change
        int          i;
        sd         = 1'b0;
        lfsr_state = 32'h4e69;
        word       = '0;
        prev_sck   = 1'b0;
        prev_ws    = 1'b0;
        pos        = 0;
        forever
        begin
            @(negedge clk);
            if (prev_sck === 1'b1 && sck === 1'b0)
            begin
                pos     = (ws !== prev_ws) ? 0 : pos + 1;
                prev_ws = ws;
                if (pos == 1)
                begin
                    for (i = 0; i < 24; i++)
                    begin
                        lfsr_state = lfsr_next(lfsr_state);
                        word       = { word [22:0], lfsr_state [0] };
                    end
                    word [23] = 1'b1;  // top 16 bits never zero
                    if (ws === 1'b0)
                        left_words.push_back(word);
                    else
                        right_words.push_back(word);
                end
                sd = (pos >= 1 && pos <= 24) ? word [24 - pos] : 1'b0;  // pos 0 is the delay bit
            end
            prev_sck = sck;
        end
    end

    // --------------------
    // dac capture model
    // --------------------

    initial
    begin : dac_model
        logic [15:0] shreg;
        logic [15:0] left_word;
        logic        prev_bclk;
        logic        have_left;
        int          fpos;  // mirrors the frame bit count
        shreg     = '0;
        left_word = '0;
        prev_bclk = 1'b0;
        have_left = 1'b0;
        fpos      = 0;
        forever
        begin
            @(negedge clk);
            if (prev_bclk === 1'b1 && bclk === 1'b0)
            begin
                fpos = (fpos + 1) % 32;
            end
            else if (prev_bclk === 1'b0 && bclk === 1'b1)
            begin
                compare_value(3, "lrclk", 24'(fpos >= 16), 24'(lrclk));  // high in the right slot
                shreg = { shreg [14:0], sdata };
                // lsb of each slot arrives at position 0 of the next one
                if (fpos == 16)
                begin
                    left_word = shreg;
                    have_left = 1'b1;
                end
                else if (fpos == 0 && have_left)
                begin
                    dac_left.push_back(left_word);
                    dac_right.push_back(shreg);
                    have_left = 1'b0;
                end
            end
            prev_bclk = bclk;
        end
    end

    initial
    begin : overrun_monitor
        overrun_seen  = 1'b0;
        overrun_falls = 0;
        @(posedge rst_n);
        forever
        begin
            @(negedge clk);
            assert (! (overrun_seen && overrun !== 1'b1)) else
            begin
                $display("CHECK FAILED overrun expected 0x1 actual 0x%0h", overrun);
                overrun_falls++;
            end
            if (overrun === 1'b1)
                overrun_seen = 1'b1;  // sticky from here on
        end
    end

    initial
    begin : watchdog
        #(watchdog_ns);
        $display("watchdog: tests still running after %0d ns, run stopped", watchdog_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    // --------------------
    // stimulus and compare
    // --------------------

    initial
    begin : run_tests
        logic [15:0] out_word;
        int          n_out;     // frames compared
        int          nz;        // nonzero words seen
        int          next_idx;  // first left word still free to match
        int          j;
        int          t;
        int          failed_tests;
        int          total_err;
        bit          found;
        bit          from_right;
        rst_n  = 1'b0;
        checks = 0;
        foreach (test_err [k])
            test_err [k] = 0;

        repeat (reset_cycles)
        begin
            @(negedge clk);
            expect_outputs_low();
        end
        rst_n = 1'b1;
        @(negedge clk);
        expect_outputs_low();
        report_test(1, "reset state");

        n_out    = 0;
        nz       = 0;
        next_idx = 0;
        while (n_out < test_frames)
        begin
            while (dac_left.size() <= n_out)
                @(negedge clk);
            out_word = dac_left [n_out];
            compare_value(3, "sdata right word", 24'(out_word), 24'(dac_right [n_out]));
            if (out_word != 16'h0)
            begin
                if (nz < first_words)
                begin
                    compare_value(2, "sdata left word",
                                  24'(mic_to_pcm(left_words [nz])), 24'(out_word));
                    next_idx = nz + 1;
                    if (nz == first_words - 1)
                        report_test(2, "order and content");
                end
                else
                begin
                    found = 1'b0;
                    j     = next_idx;
                    while (! found && j < left_words.size())
                    begin
                        if (mic_to_pcm(left_words [j]) == out_word)
                            found = 1'b1;
                        else
                            j++;
                    end
                    from_right = 1'b0;
                    foreach (right_words [k])
                        if (mic_to_pcm(right_words [k]) == out_word)
                            from_right = 1'b1;
                    checks++;
                    assert (found || ! from_right) else
                    begin
                        $display("frame %0d plays 0x%0h, a word from the right microphone slot",
                                 n_out, out_word);
                        test_err [4]++;
                    end
                    assert (found || from_right) else
                    begin
                        $display("frame %0d plays 0x%0h, which is no later left microphone word",
                                 n_out, out_word);
                        test_err [5]++;
                    end
                    if (found)
                        next_idx = j + 1;
                end
                nz++;
            end
            n_out++;
        end

        if (nz < first_words)
        begin
            $display("only %0d nonzero output words in %0d frames", nz, test_frames);
            test_err [2]++;
            report_test(2, "order and content");
        end
        report_test(3, "channel duplication");
        report_test(4, "right microphone slot ignored");
        report_test(5, $sformatf("back-pressure, %0d played, %0d dropped", nz, next_idx - nz));

        checks++;
        assert (overrun_seen) else
        begin
            $display("overrun never went high although the microphone outpaces playback");
            test_err [6]++;
        end
        test_err [6] += overrun_falls;
        report_test(6, "overrun");

        total_err    = 0;
        failed_tests = 0;
        for (t = 1; t <= 6; t++)
        begin
            total_err += test_err [t];
            if (test_err [t] != 0)
                failed_tests++;
        end
        $display("summary: 6 tests, %0d failed, %0d checks, %0d errors",
                 failed_tests, checks, total_err);
        if (total_err == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- build.f
src/audio_pkg.sv
src/mic_i2s_receiver.sv
src/sample_fifo.sv
src/i2s_audio_out.sv
src/audio_loopback_top.sv
dv/tb_audio_loopback.sv

//--- Makefile
TOP := tb_audio_loopback

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed, see sim.log"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
